// File: verilog/icache_pkg.sv
`default_nettype none

package icache_pkg;

   // ==================================================
   // cache geometry
   // ==================================================
   localparam int LINE_WORDS = 8;               // instruction words per line
   localparam int OFFSET_W   = 5;               // byte offset inside a 32-byte line

   typedef logic [31:0]              addr_t;    // byte address
   typedef logic [31:0]              word_t;    // one instruction word
   typedef logic [LINE_WORDS*32-1:0] line_t;    // word 0 sits in the low bits

   // ==================================================
   // fetch side
   // ==================================================
   typedef struct packed {
      logic  valid;
      addr_t addr;                               // byte address of the wanted word
   } fetch_req_t;

   typedef struct packed {
      logic  valid;
      logic  err;                                // refill saw a bus error
      word_t data;
   } fetch_rsp_t;

   // one line install, the RAMs pull index and tag out of addr
   typedef struct packed {
      logic  en;
      addr_t addr;
      line_t line;
   } line_wr_t;

   // lookup controller states
   typedef enum logic [1:0] {
      IDLE,
      LOOKUP,
      MISS,
      REPLAY
   } ctrl_state_e;

endpackage

`default_nettype wire

// File: verilog/axi_lite_pkg.sv
`default_nettype none

package axi_lite_pkg;

   // read response codes as they appear on rresp
   typedef enum logic [1:0] {
      OKAY   = 2'b00,
      EXOKAY = 2'b01,
      SLVERR = 2'b10,
      DECERR = 2'b11
   } axi_resp_e;

   // read address channel, arready runs back as a single bit
   typedef struct packed {
      logic        arvalid;
      logic [31:0] araddr;
      logic [2:0]  arprot;
   } axi_ar_t;

   // read data channel, rready runs back as a single bit
   typedef struct packed {
      logic        rvalid;
      logic [31:0] rdata;
      axi_resp_e   rresp;
   } axi_r_t;

   localparam logic [2:0] ARPROT_INSN = 3'b100;  // instruction, unprivileged, secure

endpackage

`default_nettype wire

// File: verilog/icache_line_ram.sv
`timescale 1ns/1ps
`default_nettype none

module icache_line_ram #(
   parameter int INDEX_W = 8
) (
   input  logic                 clk,
   input  icache_pkg::line_wr_t wr,
   input  logic [INDEX_W-1:0]   rd_index,
   output icache_pkg::line_t    rd_line
);

   import icache_pkg::*;

   typedef logic [INDEX_W-1:0] index_t;

   line_t  mem [2**INDEX_W];                    // one entry per set
   line_t  ram_q;                               // registered array output
   index_t wr_index;

   // copy of last cycle's write, used for the bypass
   logic   wr_en_q;
   index_t wr_index_q;
   line_t  wr_line_q;

   assign wr_index = wr.addr[OFFSET_W +: INDEX_W];

   // ==================================================
   // array with a one-cycle registered read
   // ==================================================
   always_ff @(posedge clk) begin
      if (wr.en) begin
         mem[wr_index] <= wr.line;
      end
      ram_q <= mem[rd_index];                   // read happens before the write lands
   end

   always_ff @(posedge clk) begin
      wr_en_q    <= wr.en;
      wr_index_q <= wr_index;
      wr_line_q  <= wr.line;
   end

   // a read that raced the write on the same index would have seen the old line,
   // so the latched write data wins whenever it matches the index being presented
   always_comb begin
      if (wr_en_q && wr_index_q == rd_index) begin
         rd_line = wr_line_q;                   // freshly installed line
      end else begin
         rd_line = ram_q;
      end
   end

   // the refill FSM comes out of reset idle, so its enable is always defined
   a_wr_en_known: assert property (@(posedge clk) !$isunknown(wr.en))
      else $error("line RAM write enable is unknown");

endmodule

`default_nettype wire

// File: verilog/icache_tag_ram.sv
`timescale 1ns/1ps
`default_nettype none

module icache_tag_ram #(
   parameter int INDEX_W = 8
) (
   input  logic                                    clk,
   input  logic                                    rst_n,
   input  icache_pkg::line_wr_t                    wr,
   input  logic                                    flush,
   input  logic [INDEX_W-1:0]                      rd_index,
   output logic                                    rd_valid,
   output logic [31-icache_pkg::OFFSET_W-INDEX_W:0] rd_tag
);

   import icache_pkg::*;

   localparam int TAG_W = 32 - OFFSET_W - INDEX_W;

   typedef logic [INDEX_W-1:0] index_t;
   typedef logic [TAG_W-1:0]   tag_t;

   tag_t                  tags [2**INDEX_W];    // no reset, guarded by the valid bits
   logic [2**INDEX_W-1:0] valid;
   tag_t                  tag_q;
   logic                  valid_q;
   index_t                wr_index;
   tag_t                  wr_tag;
   logic                  wr_en_q;
   index_t                wr_index_q;
   tag_t                  wr_tag_q;

   assign wr_index = wr.addr[OFFSET_W +: INDEX_W];
   assign wr_tag   = wr.addr[31 -: TAG_W];

   always_ff @(posedge clk) begin
      if (wr.en) begin
         tags[wr_index] <= wr_tag;
      end
      tag_q      <= tags[rd_index];
      wr_index_q <= wr_index;
      wr_tag_q   <= wr_tag;
   end

   // ==================================================
   // valid bits, cleared together by reset or flush
   // ==================================================
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         valid   <= '0;
         valid_q <= 1'b0;
         wr_en_q <= 1'b0;
      end else begin
         if (flush) begin
            valid <= '0;
         end else if (wr.en) begin
            valid[wr_index] <= 1'b1;
         end
         valid_q <= valid[rd_index] && !flush;  // a read in the flush cycle sees it empty
         wr_en_q <= wr.en;
      end
   end

   // same bypass rule as the line RAM so tag and line agree on the replay
   always_comb begin
      if (wr_en_q && wr_index_q == rd_index) begin
         rd_valid = 1'b1;
         rd_tag   = wr_tag_q;
      end else begin
         rd_valid = valid_q;
         rd_tag   = tag_q;
      end
   end

   // flush only comes while the controller waits, never during a refill install
   a_no_flush_on_write: assert property (@(posedge clk) disable iff (!rst_n)
      !(flush && wr.en))
      else $error("flush collided with a line install");

endmodule

`default_nettype wire

// File: verilog/icache_refill.sv
`timescale 1ns/1ps
`default_nettype none

module icache_refill (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  start,
   input  icache_pkg::addr_t     miss_addr,
   output axi_lite_pkg::axi_ar_t ar,
   input  logic                  arready,
   input  axi_lite_pkg::axi_r_t  r,
   output logic                  rready,
   output icache_pkg::line_wr_t  wr,
   output logic                  done,
   output logic                  err
);

   import icache_pkg::*;
   import axi_lite_pkg::*;

   typedef enum logic [1:0] {
      IDLE,
      ADDR,                                     // arvalid up, waiting for arready
      DATA                                      // rready up, waiting for the beat
   } refill_state_e;

   typedef logic [OFFSET_W-3:0]  beat_t;        // word number inside the line
   typedef logic [31:OFFSET_W]   line_num_t;    // address bits above the line offset

   refill_state_e state;
   beat_t         beat;
   line_num_t     line_num;
   line_t         fill;                         // shift register, newest word enters on top
   logic          beat_fire;
   logic          beat_bad;
   logic          last_beat;

   assign beat_fire = (state == DATA) && r.rvalid;  // rready is high for all of DATA
   assign beat_bad  = r.rresp != OKAY;
   assign last_beat = beat == beat_t'(LINE_WORDS - 1);

   // ==================================================
   // bus side
   // ==================================================
   assign ar = '{arvalid: state == ADDR,
                 araddr:  {line_num, beat, 2'b00},  // line base plus 4 per word
                 arprot:  ARPROT_INSN};
   assign rready = state == DATA;

   // done and err go out in the beat cycle so the controller can answer next cycle
   assign done = beat_fire && (beat_bad || last_beat);
   assign err  = beat_fire && beat_bad;

   // the eighth good beat joins the seven already shifted in and installs at once
   assign wr = '{en:   beat_fire && last_beat && !beat_bad,
                 addr: {line_num, {OFFSET_W{1'b0}}},
                 line: {r.rdata, fill[$bits(line_t)-1:32]}};

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= IDLE;
         beat  <= '0;
      end else begin
         case (state)
            IDLE: begin
               if (start) begin
                  state <= ADDR;
                  beat  <= '0;
               end
            end
            ADDR: begin
               if (arready) begin
                  state <= DATA;                // one read outstanding at a time
               end
            end
            DATA: begin
               if (beat_fire) begin
                  if (beat_bad || last_beat) begin
                     state <= IDLE;             // an error drops the rest of the line
                  end else begin
                     beat  <= beat + 1'b1;
                     state <= ADDR;
                  end
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == IDLE && start) begin
         line_num <= miss_addr[31:OFFSET_W];
      end
      if (beat_fire) begin
         fill <= {r.rdata, fill[$bits(line_t)-1:32]};
      end
   end

   // AXI needs the address to hold until arready takes it
   a_ar_stable: assert property (@(posedge clk) disable iff (!rst_n)
      ar.arvalid && !arready |=> ar.arvalid && $stable(ar.araddr))
      else $error("araddr moved while arvalid waited");

   // the controller waits in MISS until done, so a second start means lost sync
   a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
      start |-> state == IDLE)
      else $error("refill started while busy");

endmodule

`default_nettype wire

// File: verilog/icache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl #(
   parameter int INDEX_W = 8
) (
   input  logic                                    clk,
   input  logic                                    rst_n,
   input  icache_pkg::fetch_req_t                  req,
   output logic                                    req_ready,
   output icache_pkg::fetch_rsp_t                  rsp,
   input  logic                                    rsp_ready,
   output logic [INDEX_W-1:0]                      rd_index,
   input  icache_pkg::line_t                       rd_line,
   input  logic                                    rd_valid,
   input  logic [31-icache_pkg::OFFSET_W-INDEX_W:0] rd_tag,
   output logic                                    refill_start,
   output icache_pkg::addr_t                       miss_addr,
   input  logic                                    refill_done,
   input  logic                                    refill_err
);

   import icache_pkg::*;

   localparam int TAG_W = 32 - OFFSET_W - INDEX_W;

   ctrl_state_e state;
   ctrl_state_e state_nx;
   addr_t       lk_addr;                        // address of the lookup in flight
   word_t       hit_word;
   logic        live;                           // low for the first cycle out of reset
   logic        accept, hit, rsp_free, rsp_load;
   logic        rsp_valid;
   logic        rsp_err;
   word_t       rsp_data;

   assign rsp_free = !rsp_valid || rsp_ready;   // response slot empty by the next edge
   assign hit      = rd_valid && rd_tag == lk_addr[31 -: TAG_W];
   assign hit_word = rd_line[{lk_addr[OFFSET_W-1:2], 5'd0} +: 32];  // word by bits 4:2

   // REPLAY takes nothing new, the bypass only matches while the index holds
   assign req_ready = live && rsp_free && (state == IDLE || (state == LOOKUP && hit));
   assign accept    = req.valid && req_ready;
   assign rd_index  = accept ? req.addr[OFFSET_W +: INDEX_W] : lk_addr[OFFSET_W +: INDEX_W];
   assign miss_addr = lk_addr;
   assign rsp       = '{valid: rsp_valid, err: rsp_err, data: rsp_data};

   // ==================================================
   // lookup FSM
   // ==================================================
   always_comb begin
      state_nx     = state;
      rsp_load     = 1'b0;
      refill_start = 1'b0;
      case (state)
         IDLE: if (accept) state_nx = LOOKUP;
         LOOKUP, REPLAY: begin
            if (rsp_free) begin                 // otherwise hold and let the RAM re-read
               if (hit) begin
                  rsp_load = 1'b1;
                  state_nx = accept ? LOOKUP : IDLE;  // streams at one hit per cycle
               end else begin
                  refill_start = 1'b1;
                  state_nx     = MISS;
               end
            end
         end
         MISS: begin
            if (refill_done) begin
               rsp_load = refill_err;           // an error answers straight away
               state_nx = refill_err ? IDLE : REPLAY;
            end
         end
         default: state_nx = IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state     <= IDLE;
         rsp_valid <= 1'b0;
         live      <= 1'b0;
      end else begin
         state <= state_nx;
         live  <= 1'b1;
         if (rsp_load) begin
            rsp_valid <= 1'b1;
         end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (accept) lk_addr <= req.addr;
      if (rsp_load) begin
         rsp_err  <= state == MISS;             // loads out of MISS only on an error
         rsp_data <= (state == MISS) ? '0 : hit_word;
      end
   end

   a_rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
      rsp.valid && !rsp_ready |=> rsp.valid && $stable(rsp))
      else $error("response changed before it was taken");

   // the install and both RAM bypasses have to line up for the replay to hit
   a_replay_hits: assert property (@(posedge clk) disable iff (!rst_n)
      state == REPLAY |-> hit)
      else $error("replay after refill missed");

endmodule

`default_nettype wire

// File: verilog/icache_top.sv
`timescale 1ns/1ps
`default_nettype none

module icache_top #(
   parameter int INDEX_W = 8                    // 256 sets
) (
   input  logic                   clk,
   input  logic                   rst_n,
   input  icache_pkg::fetch_req_t req,
   output logic                   req_ready,
   output icache_pkg::fetch_rsp_t rsp,
   input  logic                   rsp_ready,
   input  logic                   flush,
   output axi_lite_pkg::axi_ar_t  ar,
   input  logic                   arready,
   input  axi_lite_pkg::axi_r_t   r,
   output logic                   rready
);

   import icache_pkg::*;

   line_wr_t                     line_wr;       // refill install, shared by both RAMs
   line_t                        rd_line;
   logic [INDEX_W-1:0]           rd_index;
   logic                         rd_valid;
   logic [31-OFFSET_W-INDEX_W:0] rd_tag;
   addr_t                        miss_addr;
   logic                         refill_start;
   logic                         refill_done;
   logic                         refill_err;

   // ==================================================
   // storage
   // ==================================================
   icache_line_ram #(.INDEX_W(INDEX_W)) u_line_ram (
      .clk      (clk),
      .wr       (line_wr),
      .rd_index (rd_index),
      .rd_line  (rd_line)
   );

   icache_tag_ram #(.INDEX_W(INDEX_W)) u_tag_ram (
      .clk      (clk),
      .rst_n    (rst_n),
      .wr       (line_wr),
      .flush    (flush),
      .rd_index (rd_index),
      .rd_valid (rd_valid),
      .rd_tag   (rd_tag)
   );

   // ==================================================
   // control and refill
   // ==================================================
   icache_ctrl #(.INDEX_W(INDEX_W)) u_ctrl (
      .clk          (clk),
      .rst_n        (rst_n),
      .req          (req),
      .req_ready    (req_ready),
      .rsp          (rsp),
      .rsp_ready    (rsp_ready),
      .rd_index     (rd_index),
      .rd_line      (rd_line),
      .rd_valid     (rd_valid),
      .rd_tag       (rd_tag),
      .refill_start (refill_start),
      .miss_addr    (miss_addr),
      .refill_done  (refill_done),
      .refill_err   (refill_err)
   );

   icache_refill u_refill (
      .clk       (clk),
      .rst_n     (rst_n),
      .start     (refill_start),
      .miss_addr (miss_addr),
      .ar        (ar),
      .arready   (arready),
      .r         (r),
      .rready    (rready),
      .wr        (line_wr),
      .done      (refill_done),
      .err       (refill_err)
   );

endmodule

`default_nettype wire

// File: sim/icache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module icache_tb;

   import icache_pkg::*;
   import axi_lite_pkg::*;

   localparam int         CLK_PERIOD = 8;
   localparam int         RESET_CYC  = 16;
   localparam int         VEC_CYC    = 200;      // watchdog budget for each vector
   localparam int         BEATS      = 8;        // AR transactions in a full refill
   localparam addr_t      ERR_BASE   = 32'hf000_0000; // memory answers SLVERR from here up
   localparam logic [2:0] AR_PROT    = 3'b100;   // instruction, unprivileged, secure

   // one line of the vector file
   typedef struct packed {
      logic [7:0] cmd;                           // "F" fetch or "X" flush
      addr_t      addr;
      word_t      word;
      logic       miss;
      logic       err;
   } vec_t;

   logic       clk;
   logic       rst_n;
   fetch_req_t req;
   logic       req_ready;
   fetch_rsp_t rsp;
   logic       rsp_ready;
   logic       flush;
   axi_ar_t    ar;
   logic       arready;
   axi_r_t     r;
   logic       rready;

   vec_t        vecs[$];                         // whole vector file loaded before the run
   vec_t        expected[$];                     // fetches accepted but not yet answered
   int          ar_count = 0;                    // AR handshakes since the last response
   logic        vectors_loaded = 1'b0;
   logic [31:0] lfsr = 32'h49c1_a49e;

   icache_top #(.INDEX_W(8)) DUT (
      .clk       (clk),
      .rst_n     (rst_n),
      .req       (req),
      .req_ready (req_ready),
      .rsp       (rsp),
      .rsp_ready (rsp_ready),
      .flush     (flush),
      .ar        (ar),
      .arready   (arready),
      .r         (r),
      .rready    (rready)
   );

   // ==================================================
   // helpers
   // ==================================================
   // fibonacci LFSR with taps 32 22 2 1 that steps once for every bit handed out
   function automatic int random_bits(input int n);
      int   v;
      logic fb;
      v = 0;
      for (int i = 0; i < n; i++) begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         v    = (v << 1) | int'(fb);
      end
      return v;
   endfunction

   task automatic stop_run(input string why);
      $display("Test failed");
      $fatal(1, "%s", why);
   endtask

   task automatic report_value(input string what);
      $display("ERR at %0t ns: %s", $time, what);
      stop_run("a DUT response did not match its vector");
   endtask

   task automatic load_vectors();
      int               fd;
      int               code;
      int               m;
      int               e;
      logic [7:0]       cmd;
      logic [31:0]      a;
      logic [31:0]      w;
      logic [8*160-1:0] rest;
      vec_t             v;
      fd = $fopen("sim/icache_vectors.txt", "r");
      if (fd == 0) begin
         stop_run("cannot open sim/icache_vectors.txt");
      end else begin
         code = $fscanf(fd, "%s", cmd);
         while (code == 1) begin
            if (cmd == "#") begin
               code = $fgets(rest, fd);         // comment line whose rest is skipped
            end else begin
               code = $fscanf(fd, "%h %h %d %d", a, w, m, e);
               if (code != 4) begin
                  stop_run("malformed record in the vector file");
               end else begin
                  v = '{cmd: cmd, addr: a, word: w, miss: m[0], err: e[0]};
                  vecs.push_back(v);
               end
            end
            code = $fscanf(fd, "%s", cmd);
         end
         $fclose(fd);
      end
   endtask

   // ==================================================
   // clock, reset and watchdog
   // ==================================================
   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial begin
      rst_n = 1'b0;
      repeat (RESET_CYC) @(posedge clk);
      #1;
      // every handshake output sits low while the cache is held in reset
      assert (!req_ready && !rsp.valid && !ar.arvalid && !rready) else
         report_value("an output was high at the end of reset");
      rst_n = 1'b1;                              // released 1 ns after the edge
   end

   initial begin : watchdog
      longint limit;
      wait (vectors_loaded);
      limit = longint'(CLK_PERIOD) * (2 * RESET_CYC + VEC_CYC * vecs.size());
      #(limit);
      stop_run("watchdog expired before the vectors were finished");
   end

   // ==================================================
   // AXI memory model with one read in flight
   // ==================================================
   initial begin : axi_memory
      addr_t beat_addr;
      addr_t want_addr;
      vec_t  cur_fetch;
      int    delay;
      logic  busy;
      logic  taken;
      arready   = 1'b0;
      r         = '0;
      beat_addr = '0;
      delay     = 0;
      busy      = 1'b0;
      taken     = 1'b0;
      wait (rst_n === 1'b1);
      forever begin
         @(posedge clk);
         #1;
         if (taken) begin                        // beat went across at this edge
            r     = '0;
            busy  = 1'b0;
            taken = 1'b0;
         end
         if (busy && !r.rvalid) begin
            if (delay == 0) begin
               r.rvalid = 1'b1;
               r.rdata  = beat_addr ^ 32'hc0de_0000;  // word rule of the memory
               if (beat_addr >= ERR_BASE) begin
                  r.rresp = SLVERR;
               end else begin
                  r.rresp = OKAY;
               end
            end else begin
               delay = delay - 1;
            end
         end
         arready = !busy && random_bits(1) == 1; // about half the cycles ready
         @(negedge clk);
         if (ar.arvalid && arready) begin
            assert (ar.arprot == AR_PROT) else
               report_value($sformatf("arprot %b, expected %b", ar.arprot, AR_PROT));
            assert (expected.size() != 0) else
               stop_run("an AR was issued with no fetch outstanding");
            // the k-th read of a refill goes to the line base plus 4k
            cur_fetch = expected[expected.size() - 1];
            want_addr = {cur_fetch.addr[31:5], ar_count[2:0], 2'b00};
            assert (ar.araddr == want_addr) else
               report_value($sformatf("AR %0d of fetch %h went to %h, expected %h",
                                      ar_count, cur_fetch.addr, ar.araddr, want_addr));
            busy      = 1'b1;
            beat_addr = ar.araddr;
            delay     = random_bits(2);          // zero to three idle cycles before rvalid
            ar_count  = ar_count + 1;
         end
         if (r.rvalid && rready) taken = 1'b1;
      end
   end

   // response back-pressure keeps rsp_ready high three cycles out of four on average
   initial begin : rsp_stalls
      rsp_ready = 1'b0;
      wait (rst_n === 1'b1);
      forever begin
         @(posedge clk);
         #1 rsp_ready = random_bits(2) != 0;
      end
   end

   // ==================================================
   // response checks sampled mid-cycle
   // ==================================================
   initial begin : response_check
      vec_t exp_v;
      int   ars;
      forever begin
         @(negedge clk);
         if (rst_n === 1'b1 && rsp.valid && rsp_ready) begin
            if (expected.size() == 0) begin
               stop_run("the DUT answered with no fetch outstanding");
            end else begin
               exp_v    = expected.pop_front();
               ars      = ar_count;             // every AR since the last answer is this fetch
               ar_count = 0;
               if (exp_v.err) begin
                  assert (rsp.err) else
                     report_value($sformatf("fetch %h returned no error", exp_v.addr));
                  assert (ars >= 1 && ars <= BEATS) else
                     report_value($sformatf("fetch %h issued %0d ARs", exp_v.addr, ars));
               end else begin
                  assert (!rsp.err) else
                     report_value($sformatf("fetch %h returned an error", exp_v.addr));
                  assert (rsp.data == exp_v.word) else
                     report_value($sformatf("fetch %h returned %h, expected %h",
                                            exp_v.addr, rsp.data, exp_v.word));
                  assert (ars == (exp_v.miss ? BEATS : 0)) else
                     report_value($sformatf("fetch %h issued %0d ARs, miss expected %0b",
                                            exp_v.addr, ars, exp_v.miss));
               end
            end
         end
      end
   end

   // ==================================================
   // vector player
   // ==================================================
   initial begin : player
      vec_t v;
      req   = '0;
      flush = 1'b0;
      load_vectors();
      vectors_loaded = 1'b1;
      wait (rst_n === 1'b1);
      @(posedge clk);
      #1;
      foreach (vecs[i]) begin
         v = vecs[i];
         if (v.cmd == "X") begin
            req.valid = 1'b0;
            while (expected.size() != 0) @(posedge clk);  // flush only between fetches
            @(posedge clk);
            #1 flush = 1'b1;
            @(posedge clk);
            #1 flush = 1'b0;
         end else begin
            req.valid = 1'b1;
            req.addr  = v.addr;
            @(negedge clk);
            while (!req_ready) @(negedge clk);
            expected.push_back(v);               // taken at the coming edge
            @(posedge clk);
            #1 req.valid = 1'b0;                 // next fetch may raise it again right away
         end
      end
      while (expected.size() != 0) @(posedge clk);
      repeat (4) @(posedge clk);
      $display("Test passed");
      $finish;
   end

endmodule

`default_nettype wire

// File: sim/icache_vectors.txt
# cmd addr word miss err, all hex except the last two bits
# F fetches addr, X flushes the cache and ignores the other columns
F 00001000 c0de1000 1 0
F 00001004 c0de1004 0 0
F 00001008 c0de1008 0 0
F 0000100c c0de100c 0 0
F 00001010 c0de1010 0 0
F 00001014 c0de1014 0 0
F 00001018 c0de1018 0 0
F 0000101c c0de101c 0 0
F 00002014 c0de2014 1 0
F 00002000 c0de2000 0 0
F 0000201c c0de201c 0 0
F 00003008 c0de3008 1 0
F 00001000 c0de1000 1 0
F 00001010 c0de1010 0 0
F 00003008 c0de3008 1 0
F 12345678 d2ea5678 1 0
F 1234567c d2ea567c 0 0
F 12345660 d2ea5660 0 0
F 00001fe0 c0de1fe0 1 0
F 00001ffc c0de1ffc 0 0
F 80000020 40de0020 1 0
F 8000003c 40de003c 0 0
X 00000000 00000000 0 0
F 00002004 c0de2004 1 0
F 12345664 d2ea5664 1 0
F 00001ff0 c0de1ff0 1 0
F f0000040 00000000 1 1
F f0000040 00000000 1 1
F f0000044 00000000 1 1
F fffffffc 00000000 1 1
F 00003000 c0de3000 1 0
F f0001000 00000000 1 1
F 00003014 c0de3014 0 0
F 00003018 c0de3018 0 0

// File: run_sim.sh
#!/bin/sh
# builds the icache testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   -f verilog.f --top-module icache_tb -o icache_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/icache_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -q "^Test passed$"; then
   exit 0
fi
echo "pass message not found in the simulation output"
exit 1

// File: verilog.f
verilog/icache_pkg.sv
verilog/axi_lite_pkg.sv
verilog/icache_line_ram.sv
verilog/icache_tag_ram.sv
verilog/icache_refill.sv
verilog/icache_ctrl.sv
verilog/icache_top.sv
sim/icache_tb.sv
